/* uart_phy.f */
common/uart_phy_pkg.sv
hdl/baud_tick_gen.sv
uart_rx/uart_rx.sv
uart_tx/uart_tx.sv
hdl/uart_wb_regs.sv
hdl/uart_phy_top.sv
tb/uart_phy_tb.sv

/* tb/uart_phy_tb.sv */
`default_nettype none

module uart_phy_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import uart_phy_pkg::*;

  localparam int bit_clocks  = 32;    // Divisor 1 gives a tick every 2 clocks
  localparam int ack_timeout = 16;    // Clocks allowed for wb_ack
  localparam int poll_limit  = 1000;  // STATUS reads before giving up

  logic        clock, reset;
  logic        wb_cyc, wb_stb, wb_we;
  wb_addr_t    wb_adr;
  wb_data_t    wb_dat_i, wb_dat_o;
  logic        wb_ack;
  logic        rxd, txd;
  logic        loopback;  // 1 ties rxd to txd
  logic        rxd_drv;   // Line from the serial driver
  int unsigned seed;

  assign rxd = loopback ? txd : rxd_drv;

  uart_phy_top UUT (
    .clock    (clock),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack),
    .rxd      (rxd),
    .txd      (txd)
  );

  always #4 clock = ~clock;  // 8 ns period

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_status(input string name, input wb_data_t got, input wb_data_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Expected STATUS word built from the register map
  function automatic wb_data_t status_word(input logic busy, input logic full,
                                           input logic valid, input logic ferr,
                                           input logic perr, input logic ovr);
    wb_data_t w;
    w                  = '0;
    w[st_tx_busy]      = busy;
    w[st_rx_full]      = full;
    w[st_data_valid]   = valid;
    w[st_frame_error]  = ferr;
    w[st_parity_error] = perr;
    w[st_overrun]      = ovr;
    return w;
  endfunction

  function automatic wb_data_t ctrl_value(input logic en, input parity_t par,
                                          input logic two_stop);
    wb_data_t w;
    w                      = '0;
    w[ctrl_rx_en]          = en;
    w[ctrl_parity_lo +: 2] = par;
    w[ctrl_nstop]          = two_stop;
    return w;
  endfunction

  // Classic single write, held until ack
  task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
    int cycles;
    cycles = 0;
    @(posedge clock);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_i <= dat;
    @(posedge clock);
    while (!wb_ack) begin
      if (cycles == ack_timeout) begin
        $display("Timeout: no wb_ack for the write to address %0d", adr);
        abort_run();
      end
      cycles++;
      @(posedge clock);
    end
    wb_cyc <= 1'b0;  // Released on the ack edge
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
    int cycles;
    cycles = 0;
    @(posedge clock);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    @(posedge clock);
    while (!wb_ack) begin
      if (cycles == ack_timeout) begin
        $display("Timeout: no wb_ack for the read of address %0d", adr);
        abort_run();
      end
      cycles++;
      @(posedge clock);
    end
    dat    = wb_dat_o;  // Valid together with ack
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic wait_rx_full(output wb_data_t st);
    int polls;
    polls = 0;
    wb_read(addr_status, st);
    while (!st[st_rx_full]) begin
      if (polls == poll_limit) begin
        $display("Timeout: rx_full never came up in STATUS");
        abort_run();
      end
      polls++;
      wb_read(addr_status, st);
    end
  endtask

  task automatic drive_bit(input logic b);
    @(posedge clock);
    rxd_drv <= b;
    repeat (bit_clocks - 1) @(posedge clock);
  endtask

  // Start, LSB first data, optional parity, stops, then one idle bit
  task automatic send_serial_frame(input byte_t d, input parity_t par, input logic two_stop,
                                   input logic bad_parity, input logic stop_low);
    logic par_bit;
    par_bit = (par == 2'd3) ? ~(^d) : ^d;  // Odd parity inverts the XOR
    par_bit = par_bit ^ bad_parity;
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) drive_bit(d[i]);
    if (par[1]) drive_bit(par_bit);
    drive_bit(~stop_low);
    if (two_stop) drive_bit(1'b1);
    drive_bit(1'b1);
  endtask

  // Byte out through txd and back in through rxd
  task automatic loopback_byte(input wb_data_t ctrl);
    byte_t    d;
    wb_data_t st;
    wb_data_t rd;
    d = byte_t'($urandom);
    wb_write(addr_ctrl, ctrl);
    wb_write(addr_data, {24'h000000, d});
    wb_read(addr_status, st);
    check_status("STATUS.tx_busy", st & status_word(1, 0, 0, 0, 0, 0),
                 status_word(1, 0, 0, 0, 0, 0));
    wait_rx_full(st);
    check_status("STATUS", st, status_word(0, 1, 1, 0, 0, 0));
    wb_read(addr_data, rd);
    check_byte("DATA", rd[7:0], d);
    wb_read(addr_status, st);
    check_status("STATUS", st, status_word(0, 0, 1, 0, 0, 0));  // rx_full gone
  endtask

  task automatic test_register_access();
    wb_data_t rd;
    wb_read(addr_status, rd);
    check_status("STATUS", rd, '0);
    wb_write(addr_ctrl, ctrl_value(1'b1, 2'd3, 1'b1));
    wb_read(addr_ctrl, rd);
    check_status("CTRL", rd, ctrl_value(1'b1, 2'd3, 1'b1));
    wb_write(addr_divisor, 32'h0000_0015);  // Small, the reload comes soon
    wb_read(addr_divisor, rd);
    check_status("DIVISOR", rd, 32'h0000_0015);
    wb_write(addr_divisor, 32'h0000_0001);  // Serial tests run at 32 clocks a bit
  endtask

  // Transmitter alone, txd sampled in the middle of every bit
  task automatic test_tx_frame();
    byte_t    d;
    logic     exp_bits [0:10];
    wb_data_t st;
    int       cycles;
    cycles = 0;
    d      = byte_t'($urandom);
    check_bit("txd", txd, 1'b1);  // Idle line
    exp_bits[0] = 1'b0;
    for (int i = 0; i < 8; i++) exp_bits[i + 1] = d[i];
    exp_bits[9]  = ~(^d);  // Odd parity makes the count of ones odd
    exp_bits[10] = 1'b1;
    wb_write(addr_ctrl, ctrl_value(1'b0, 2'd3, 1'b0));
    wb_write(addr_data, {24'h000000, d});
    while (txd) begin
      if (cycles == bit_clocks) begin
        $display("Timeout: no start bit on txd");
        abort_run();
      end
      cycles++;
      @(posedge clock);
    end
    repeat (bit_clocks / 2) @(posedge clock);
    for (int i = 0; i < 11; i++) begin
      check_bit("txd", txd, exp_bits[i]);
      repeat (bit_clocks) @(posedge clock);
    end
    wb_read(addr_status, st);
    check_status("STATUS", st, '0);  // tx_busy gone, nothing received
  endtask

  task automatic test_loopback_formats();
    loopback_byte(ctrl_value(1'b1, 2'd0, 1'b0));
    loopback_byte(ctrl_value(1'b1, 2'd2, 1'b1));  // Even, two stops
    loopback_byte(ctrl_value(1'b1, 2'd3, 1'b0));  // Odd, one stop
  endtask

  task automatic test_error_detection();
    byte_t    d;
    wb_data_t st;
    wb_data_t rd;
    @(posedge clock);
    loopback <= 1'b0;
    wb_write(addr_ctrl, ctrl_value(1'b1, 2'd2, 1'b0));
    d = byte_t'($urandom);
    send_serial_frame(d, 2'd2, 1'b0, 1'b1, 1'b0);  // Parity bit flipped
    wait_rx_full(st);
    check_status("STATUS", st, status_word(0, 1, 0, 0, 1, 0));
    wb_read(addr_data, rd);
    check_byte("DATA", rd[7:0], d);
    wb_write(addr_ctrl, ctrl_value(1'b1, 2'd0, 1'b0));
    d = byte_t'($urandom);
    send_serial_frame(d, 2'd0, 1'b0, 1'b0, 1'b1);  // Stop bit low
    wait_rx_full(st);
    check_status("STATUS", st, status_word(0, 1, 0, 1, 0, 0));
    wb_read(addr_data, rd);
    check_byte("DATA", rd[7:0], d);
  endtask

  task automatic test_false_start();
    wb_data_t st;
    @(posedge clock);
    rxd_drv <= 1'b0;  // 5 clocks low, well under half a bit
    repeat (5) @(posedge clock);
    rxd_drv <= 1'b1;
    repeat (12) drive_bit(1'b1);  // Longer than a whole frame
    wb_read(addr_status, st);
    check_status("STATUS", st, status_word(0, 0, 0, 1, 0, 0));  // Flags of the last frame
    wb_write(addr_ctrl, ctrl_value(1'b0, 2'd0, 1'b0));
    send_serial_frame(byte_t'($urandom), 2'd0, 1'b0, 1'b0, 1'b0);
    repeat (2) drive_bit(1'b1);
    wb_read(addr_status, st);
    check_status("STATUS", st, status_word(0, 0, 0, 1, 0, 0));
  endtask

  task automatic test_overrun();
    byte_t    d1, d2;
    wb_data_t st;
    wb_data_t rd;
    d1 = byte_t'($urandom);
    d2 = byte_t'($urandom);
    if (d2 == d1) d2 = ~d1;
    wb_write(addr_ctrl, ctrl_value(1'b1, 2'd0, 1'b0));
    send_serial_frame(d1, 2'd0, 1'b0, 1'b0, 1'b0);
    send_serial_frame(d2, 2'd0, 1'b0, 1'b0, 1'b0);  // First byte left unread
    wait_rx_full(st);
    check_status("STATUS", st, status_word(0, 1, 1, 0, 0, 1));
    wb_read(addr_data, rd);
    check_byte("DATA", rd[7:0], d2);
    wb_read(addr_status, st);
    check_status("STATUS", st, status_word(0, 0, 1, 0, 0, 0));
  endtask

  initial begin
    seed     = $urandom(81674);
    clock    = 1'b0;
    reset    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_i = '0;
    rxd_drv  = 1'b1;  // Line idle
    loopback = 1'b1;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    test_register_access();
    test_tx_frame();
    test_loopback_formats();
    test_error_detection();
    test_false_start();
    test_overrun();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/uart_phy_top.sv */
`default_nettype none

module uart_phy_top (
  input  logic                   clock,
  input  logic                   reset,
  // Wishbone classic slave
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  uart_phy_pkg::wb_addr_t wb_adr,
  input  uart_phy_pkg::wb_data_t wb_dat_i,
  output uart_phy_pkg::wb_data_t wb_dat_o,
  output logic                   wb_ack,
  // Serial line
  input  logic                   rxd,
  output logic                   txd
);

  import uart_phy_pkg::*;

  divisor_t divisor;
  logic     tick;
  logic     rx_en, nstop;
  parity_t  parity_type;
  byte_t    tx_data, rx_data;
  logic     tx_start, tx_busy;
  logic     rx_data_valid, rx_frame_error, rx_parity_error, rx_done;

  uart_wb_regs u_regs (
    .clock           (clock),
    .reset           (reset),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_adr          (wb_adr),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack          (wb_ack),
    .divisor         (divisor),
    .rx_en           (rx_en),
    .parity_type     (parity_type),
    .nstop           (nstop),
    .tx_data         (tx_data),
    .tx_start        (tx_start),
    .tx_busy         (tx_busy),
    .rx_data         (rx_data),
    .rx_data_valid   (rx_data_valid),
    .rx_frame_error  (rx_frame_error),
    .rx_parity_error (rx_parity_error),
    .rx_done         (rx_done)
  );

  baud_tick_gen u_tick (
    .clock   (clock),
    .reset   (reset),
    .divisor (divisor),
    .tick    (tick)
  );

  // Shares the line format with the receiver
  uart_tx u_tx (
    .clock       (clock),
    .reset       (reset),
    .tick        (tick),
    .parity_type (parity_type),
    .nstop       (nstop),
    .tx_data     (tx_data),
    .tx_start    (tx_start),
    .txd         (txd),
    .tx_busy     (tx_busy)
  );

  uart_rx u_rx (
    .clock        (clock),
    .reset        (reset),
    .tick         (tick),
    .rx_en        (rx_en),
    .parity_type  (parity_type),
    .nstop        (nstop),
    .rxd          (rxd),
    .data_out     (rx_data),
    .data_valid   (rx_data_valid),
    .frame_error  (rx_frame_error),
    .parity_error (rx_parity_error),
    .rx_done      (rx_done)
  );

endmodule

`default_nettype wire

/* hdl/uart_wb_regs.sv */
`default_nettype none

module uart_wb_regs (
  input  logic                   clock,
  input  logic                   reset,
  // Wishbone classic slave
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  uart_phy_pkg::wb_addr_t wb_adr,
  input  uart_phy_pkg::wb_data_t wb_dat_i,
  output uart_phy_pkg::wb_data_t wb_dat_o,
  output logic                   wb_ack,
  // Line configuration
  output uart_phy_pkg::divisor_t divisor,
  output logic                   rx_en,
  output uart_phy_pkg::parity_t  parity_type,
  output logic                   nstop,
  // Transmitter side
  output uart_phy_pkg::byte_t    tx_data,
  output logic                   tx_start,
  input  logic                   tx_busy,
  // Receiver side
  input  uart_phy_pkg::byte_t    rx_data,
  input  logic                   rx_data_valid,
  input  logic                   rx_frame_error,
  input  logic                   rx_parity_error,
  input  logic                   rx_done
);

  import uart_phy_pkg::*;

  logic     acc;        // Access accepted this clock
  logic     wr, rd;
  logic     rd_data;    // Read of the receive buffer
  byte_t    rx_byte;    // Last received byte
  logic     rx_full, overrun;
  logic     valid_q, frame_q, parity_q;  // Flags of the last frame
  wb_data_t status;
  wb_data_t ctrl_word;

  // ack is one clock wide, so a held strobe is not accepted twice
  assign acc     = wb_cyc & wb_stb & ~wb_ack;
  assign wr      = acc & wb_we;
  assign rd      = acc & ~wb_we;
  assign rd_data = rd & (wb_adr == addr_data);

  always_comb begin
    status                  = '0;
    status[st_tx_busy]      = tx_busy;
    status[st_rx_full]      = rx_full;
    status[st_data_valid]   = valid_q;
    status[st_frame_error]  = frame_q;
    status[st_parity_error] = parity_q;
    status[st_overrun]      = overrun;
  end

  always_comb begin
    ctrl_word                             = '0;
    ctrl_word[ctrl_rx_en]                 = rx_en;
    ctrl_word[ctrl_parity_lo +: 2]        = parity_type;
    ctrl_word[ctrl_nstop]                 = nstop;
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wb_ack      <= 1'b0;
      divisor     <= '0;
      rx_en       <= 1'b0;
      parity_type <= '0;
      nstop       <= 1'b0;
      tx_start    <= 1'b0;
      rx_full     <= 1'b0;
      overrun     <= 1'b0;
      valid_q     <= 1'b0;
      frame_q     <= 1'b0;
      parity_q    <= 1'b0;
    end else begin
      wb_ack <= acc;
      if (wr && wb_adr == addr_ctrl) begin
        rx_en       <= wb_dat_i[ctrl_rx_en];
        parity_type <= wb_dat_i[ctrl_parity_lo +: 2];
        nstop       <= wb_dat_i[ctrl_nstop];
      end
      if (wr && wb_adr == addr_divisor) divisor <= wb_dat_i[15:0];
      // Dropped while a byte is in flight
      tx_start <= wr & (wb_adr == addr_data) & ~tx_busy & ~tx_start;
      if (rx_done) begin
        valid_q  <= rx_data_valid;
        frame_q  <= rx_frame_error;
        parity_q <= rx_parity_error;
        rx_full  <= 1'b1;
        overrun  <= (rx_full | overrun) & ~rd_data;  // Unread byte overwritten
      end else if (rd_data) begin
        rx_full <= 1'b0;
        overrun <= 1'b0;
      end
    end
  end

  // Data path, read word valid with ack
  always_ff @(posedge clock) begin
    if (wr && wb_adr == addr_data && !tx_busy && !tx_start) tx_data <= wb_dat_i[7:0];
    if (rx_done) rx_byte <= rx_data;
    if (rd) begin
      case (wb_adr)
        addr_ctrl:    wb_dat_o <= ctrl_word;
        addr_divisor: wb_dat_o <= {16'h0000, divisor};
        addr_status:  wb_dat_o <= status;
        default:      wb_dat_o <= {24'h000000, rx_byte};
      endcase
    end
  end

  a_ack_after_req: assert property (@(posedge clock) disable iff (reset)
    wb_ack |-> $past(wb_cyc && wb_stb));

  a_no_start_busy: assert property (@(posedge clock) disable iff (reset)
    tx_start |-> !tx_busy);

endmodule

`default_nettype wire

/* uart_tx/uart_tx.sv */
`default_nettype none

module uart_tx (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  tick,         // 16x oversampling strobe
  input  uart_phy_pkg::parity_t parity_type,  // 0/1 none, 2 even, 3 odd
  input  logic                  nstop,        // 1: two stop bits
  input  uart_phy_pkg::byte_t   tx_data,
  input  logic                  tx_start,     // Load and send tx_data
  output logic                  txd,          // Serial line out, registered
  output logic                  tx_busy
);

  import uart_phy_pkg::*;

  uart_phy_fsm_t state;

  logic [3:0] sample_cnt;  // Tick position inside the current bit
  logic       bit_end;
  logic [2:0] bit_cnt;     // Data bits already on the line
  byte_t      shreg;       // Shifts out LSB first
  logic       par_bit;     // Parity bit of the loaded byte
  logic       par_en;      // Format latched with the byte
  logic       two_stop;
  logic       load;
  logic       shift_now;

  assign bit_end = tick & (sample_cnt == 4'(oversample - 1));
  assign load    = tx_start & ~tx_busy & (state == idle);

  // A data bit goes out of the shift register at these boundaries
  assign shift_now = bit_end & ((state == start) | ((state == data) & (bit_cnt != 3'd7)));

  // Byte and line format are captured at load
  always_ff @(posedge clock) begin
    if (load) begin
      shreg    <= tx_data;
      par_bit  <= (^tx_data) ^ parity_type[0];  // Inverted for odd parity
      par_en   <= parity_type[1];
      two_stop <= nstop;
    end else if (shift_now) begin
      shreg <= {1'b0, shreg[7:1]};
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sample_cnt <= '0;
    end else if (state == idle) begin
      sample_cnt <= '0;
    end else if (tick) begin
      sample_cnt <= sample_cnt + 1'b1;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state   <= idle;
      txd     <= 1'b1;  // Line idles high
      tx_busy <= 1'b0;
      bit_cnt <= '0;
    end else begin
      if (load) tx_busy <= 1'b1;
      case (state)
        idle: begin
          if (tx_busy && tick) begin  // Start bit aligned to a tick
            state <= start;
            txd   <= 1'b0;
          end
        end
        start: begin
          if (bit_end) begin
            state   <= data;
            txd     <= shreg[0];
            bit_cnt <= '0;
          end
        end
        data: begin
          if (bit_end) begin
            if (bit_cnt == 3'd7) begin
              if (par_en) begin
                state <= parity;
                txd   <= par_bit;
              end else begin
                state <= stop1;
                txd   <= 1'b1;
              end
            end else begin
              txd     <= shreg[0];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        parity: begin
          if (bit_end) begin
            state <= stop1;
            txd   <= 1'b1;
          end
        end
        stop1: begin
          if (bit_end) begin
            if (two_stop) begin
              state <= stop2;
            end else begin
              state   <= idle;
              tx_busy <= 1'b0;
            end
          end
        end
        stop2: begin
          if (bit_end) begin
            state   <= idle;
            tx_busy <= 1'b0;
          end
        end
        default: begin
          state <= idle;
          txd   <= 1'b1;
        end
      endcase
    end
  end

  a_idle_line_high: assert property (@(posedge clock) disable iff (reset)
    (state == idle) |-> txd);

endmodule

`default_nettype wire

/* uart_rx/uart_rx.sv */
`default_nettype none

module uart_rx (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  tick,          // 16x oversampling strobe
  input  logic                  rx_en,         // Receiver enable
  input  uart_phy_pkg::parity_t parity_type,   // 0/1 none, 2 even, 3 odd
  input  logic                  nstop,         // 1: two stop bits
  input  logic                  rxd,           // Serial line in
  output uart_phy_pkg::byte_t   data_out,
  output logic                  data_valid,    // Last frame had no errors
  output logic                  frame_error,
  output logic                  parity_error,
  output logic                  rx_done        // End of frame pulse
);

  import uart_phy_pkg::*;

  uart_phy_fsm_t state, next_state;

  logic [3:0] sample_cnt;  // Tick position inside the current bit
  logic       bit_end;     // Last tick of the bit
  logic [2:0] votes;       // Mid-bit samples
  logic       vote;        // Majority of the three samples
  byte_t      shreg;       // Fills from the MSB, LSB arrives first
  logic [2:0] data_cnt;    // Data bits received

  logic parity_er, frame_er;      // Running flags of the current frame
  logic parity_er_d, frame_er_d;  // Their next values

  // FSM strobes
  logic start_ok, shift_en, check_parity, check_stop, frame_end_en;

  assign bit_end = tick & (sample_cnt == 4'(oversample - 1));

  // Two of three wins
  assign vote = (votes[0] & votes[1]) | (votes[0] & votes[2]) | (votes[1] & votes[2]);

  // Sample counter, held at zero while idle so the start bit is timed from its edge
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sample_cnt <= '0;
    end else if (state == idle) begin
      sample_cnt <= '0;
    end else if (tick) begin
      sample_cnt <= sample_cnt + 1'b1;  // Wraps into the next bit
    end
  end

  // Vote registers catch ticks 7, 8 and 9 of each bit
  always_ff @(posedge clock) begin
    for (int i = 0; i < 3; i++) begin
      if (tick && sample_cnt == 4'(6 + i)) votes[i] <= rxd;
    end
  end

  // Serial to parallel
  always_ff @(posedge clock) begin
    if (shift_en) shreg <= {vote, shreg[7:1]};
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      data_cnt <= '0;
    end else if (start_ok) begin
      data_cnt <= '0;
    end else if (shift_en) begin
      data_cnt <= data_cnt + 1'b1;
    end
  end

  // Parity of data plus received bit is zero for even, one for odd
  always_comb begin
    parity_er_d = parity_er;
    frame_er_d  = frame_er;
    if (start_ok) begin
      parity_er_d = 1'b0;  // Fresh frame
      frame_er_d  = 1'b0;
    end
    if (check_parity) parity_er_d = (^shreg) ^ parity_type[0] ^ vote;
    if (check_stop)   frame_er_d  = ~vote;  // Stop bit must be high
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      parity_er    <= 1'b0;
      frame_er     <= 1'b0;
      rx_done      <= 1'b0;
      data_valid   <= 1'b0;
      frame_error  <= 1'b0;
      parity_error <= 1'b0;
    end else begin
      parity_er <= parity_er_d;
      frame_er  <= frame_er_d;
      rx_done   <= frame_end_en;  // Registered end of frame
      if (start_ok) begin
        data_valid   <= 1'b0;
        frame_error  <= 1'b0;
        parity_error <= 1'b0;
      end else if (frame_end_en) begin
        // Buffered flags settle together with rx_done
        data_valid   <= ~parity_er_d & ~frame_er_d;
        frame_error  <= frame_er_d;
        parity_error <= parity_er_d;
      end
    end
  end

  assign data_out = shreg;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) state <= idle;
    else       state <= next_state;
  end

  always_comb begin
    next_state   = state;
    start_ok     = 1'b0;
    shift_en     = 1'b0;
    check_parity = 1'b0;
    check_stop   = 1'b0;
    frame_end_en = 1'b0;
    case (state)
      idle: begin
        if (!rxd && rx_en) next_state = start;  // Possible start edge
      end
      start: begin
        if (bit_end) begin
          if (!vote) begin
            start_ok   = 1'b1;
            next_state = data;
          end else begin
            next_state = idle;  // Glitch, false start
          end
        end
      end
      data: begin
        shift_en = bit_end;
        if (bit_end && (&data_cnt)) next_state = parity_type[1] ? parity : stop1;
      end
      parity: begin
        check_parity = bit_end;
        if (bit_end) next_state = stop1;
      end
      stop1: begin
        check_stop = bit_end;
        if (bit_end) begin
          if (nstop) begin
            next_state = stop2;
          end else begin
            frame_end_en = 1'b1;
            next_state   = idle;
          end
        end
      end
      stop2: begin
        check_stop = bit_end & ~frame_er;  // Only if stop1 was good
        if (bit_end) begin
          frame_end_en = 1'b1;
          next_state   = idle;
        end
      end
      default: next_state = idle;
    endcase
  end

  a_rx_done_pulse: assert property (@(posedge clock) disable iff (reset)
    rx_done |=> !rx_done);

  a_state_legal: assert property (@(posedge clock) disable iff (reset)
    state inside {idle, start, data, parity, stop1, stop2});

endmodule

`default_nettype wire

/* hdl/baud_tick_gen.sv */
`default_nettype none

module baud_tick_gen (
  input  logic                  clock,
  input  logic                  reset,
  input  uart_phy_pkg::divisor_t divisor,  // Reload value, period is divisor+1
  output logic                  tick       // One-clock pulse at 16x baud
);

  import uart_phy_pkg::*;

  divisor_t count;  // Clocks left until the next tick

  // Down-counter, reloads from divisor on the tick
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      count <= '0;  // First tick right after reset
    end else if (count == '0) begin
      count <= divisor;  // New divisor only takes effect here
    end else begin
      count <= count - 1'b1;
    end
  end

  assign tick = (count == '0);

endmodule

`default_nettype wire

/* common/uart_phy_pkg.sv */
`default_nettype none

package uart_phy_pkg;

  // Frame states shared by receiver and transmitter
  typedef enum logic [2:0] {
    idle,
    start,
    data,
    parity,
    stop1,
    stop2
  } uart_phy_fsm_t;

  typedef logic [7:0]  byte_t;     // One serial data byte
  typedef logic [1:0]  parity_t;   // 0/1 none, 2 even, 3 odd
  typedef logic [15:0] divisor_t;  // Tick divisor, tick every divisor+1 clocks
  typedef logic [1:0]  wb_addr_t;  // Register word address
  typedef logic [31:0] wb_data_t;  // Bus data word

  // Ticks per serial bit
  localparam int oversample = 16;

  // Register map
  localparam wb_addr_t addr_ctrl    = 2'd0;
  localparam wb_addr_t addr_divisor = 2'd1;
  localparam wb_addr_t addr_status  = 2'd2;
  localparam wb_addr_t addr_data    = 2'd3;

  // Status word bit positions
  localparam int st_tx_busy      = 0;
  localparam int st_rx_full      = 1;
  localparam int st_data_valid   = 2;
  localparam int st_frame_error  = 3;
  localparam int st_parity_error = 4;
  localparam int st_overrun      = 5;

  // Control word bit positions
  localparam int ctrl_rx_en     = 0;
  localparam int ctrl_parity_lo = 1;  // Parity field spans bits 2:1
  localparam int ctrl_nstop     = 3;  // 1 selects two stop bits

endpackage

`default_nettype wire
